/* source/rename_pkg.sv */
// sizes fixed here for the whole core; every instruction is assumed to write a destination
package rename_pkg;

    ///////////////////////////////////////////////////////////////////////
    // sizes
    ///////////////////////////////////////////////////////////////////////

    localparam int num_arch_regs   = 32;  // architectural registers
    localparam int num_phys_regs   = 64;  // physical registers
    localparam int free_list_depth = num_phys_regs - num_arch_regs;  // 32 spare
    localparam int rob_depth       = 8;   // reorder buffer entries

    ///////////////////////////////////////////////////////////////////////
    // index types
    ///////////////////////////////////////////////////////////////////////

    typedef logic [$clog2(num_arch_regs)-1:0] arch_idx_t;  // 5 bits
    typedef logic [$clog2(num_phys_regs)-1:0] phys_idx_t;  // 6 bits
    typedef logic [$clog2(rob_depth)-1:0]     rob_idx_t;   // 3 bits

    ///////////////////////////////////////////////////////////////////////
    // reorder buffer entry
    ///////////////////////////////////////////////////////////////////////

    // 18 bits in total
    typedef struct packed {
        arch_idx_t arch_dest;  // destination being renamed
        phys_idx_t new_pr;     // register taken from free list
        phys_idx_t old_pr;     // previous mapping, freed at retire
        logic      done;       // set by completion
    } rob_entry_t;

endpackage

/* source/rename_ifs.sv */
// peer links inside the core; no clock travels here, all state sits in the owning modules

///////////////////////////////////////////////////////////////////////
// free list link
///////////////////////////////////////////////////////////////////////

// pop only while empty is low, head_pr valid whenever empty is low
// pop and push may both be high in the same cycle
interface free_list_if;
    logic                  pop;      // take head_pr at the edge
    rename_pkg::phys_idx_t head_pr;  // next free register
    logic                  empty;    // no free register left
    logic                  push;     // return push_pr at the edge
    rename_pkg::phys_idx_t push_pr;  // register freed by retirement

    modport owner (
        input  pop, push, push_pr,
        output head_pr, empty
    );

    modport user (
        output pop, push, push_pr,
        input  head_pr, empty
    );
endinterface

///////////////////////////////////////////////////////////////////////
// map table update link
///////////////////////////////////////////////////////////////////////

// old_pr is the mapping before this cycle's write
// the write lands at the edge where set_en is high
interface map_update_if;
    rename_pkg::arch_idx_t dest_arch;  // destination to remap
    logic                  set_en;     // write new_pr at the edge
    rename_pkg::phys_idx_t new_pr;     // new mapping
    rename_pkg::phys_idx_t old_pr;     // mapping being replaced

    modport owner (
        input  dest_arch, set_en, new_pr,
        output old_pr
    );

    modport user (
        output dest_arch, set_en, new_pr,
        input  old_pr
    );
endinterface

/* source/map_table.sv */
// one write port and two combinational reads; no checkpoint or restore, so no branch recovery
module map_table (
    input  logic                  clock,
    input  logic                  reset,
    map_update_if.owner           upd,          // dispatch remap
    input  rename_pkg::arch_idx_t lookup_arch,  // operand read
    output rename_pkg::phys_idx_t lookup_pr
);

    ///////////////////////////////////////////////////////////////////////
    // mapping storage
    ///////////////////////////////////////////////////////////////////////

    // arch reg -> current physical reg
    rename_pkg::phys_idx_t map_q [rename_pkg::num_arch_regs];

    // identity after reset, so regs 0..31 start out committed
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::num_arch_regs; i++) begin
                map_q[i] <= rename_pkg::phys_idx_t'(i);
            end
        end else if (upd.set_en) begin
            map_q[upd.dest_arch] <= upd.new_pr;  // visible from next cycle
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // reads
    ///////////////////////////////////////////////////////////////////////

    // both reads see the table before this cycle's write
    // an instruction renaming the same reg it reads gets the older mapping
    assign upd.old_pr = map_q[upd.dest_arch];  // goes into the rob entry
    assign lookup_pr  = map_q[lookup_arch];    // source operand lookup

endmodule

/* source/free_list.sv */
// circular queue sized to num_phys_regs minus num_arch_regs; it cannot overflow, so no full flag
module free_list (
    input  logic        clock,
    input  logic        reset,
    free_list_if.owner  fl
);

    typedef logic [$clog2(rename_pkg::free_list_depth)-1:0] fl_ptr_t;  // wraps at depth
    typedef logic [$clog2(rename_pkg::free_list_depth):0]   fl_cnt_t;  // 0..depth

    ///////////////////////////////////////////////////////////////////////
    // queue state
    ///////////////////////////////////////////////////////////////////////

    rename_pkg::phys_idx_t mem [rename_pkg::free_list_depth];  // free registers

    fl_ptr_t head;   // next to hand out
    fl_ptr_t tail;   // next slot for a freed reg
    fl_cnt_t count;  // regs currently free

    // pointers and count
    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;  // queue starts full, tail meets head
            count <= fl_cnt_t'(rename_pkg::free_list_depth);
        end else begin
            if (fl.pop) begin
                head <= head + 1'b1;  // power of two depth, natural wrap
            end
            if (fl.push) begin
                tail <= tail + 1'b1;
            end
            case ({fl.pop, fl.push})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;  // both or neither
            endcase
        end
    end

    // contents
    // reset loads 32..63 in order, 32 at the head
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::free_list_depth; i++) begin
                mem[i] <= rename_pkg::phys_idx_t'(rename_pkg::num_arch_regs + i);
            end
        end else if (fl.push) begin
            mem[tail] <= fl.push_pr;  // freed reg rejoins at the tail
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // outputs
    ///////////////////////////////////////////////////////////////////////

    assign fl.head_pr = mem[head];      // meaningless while empty
    assign fl.empty   = (count == '0);

endmodule

/* source/reorder_buffer.sv */
// one dispatch, one completion and one retirement per cycle; completion must name a live entry
module reorder_buffer (
    input  logic                  clock,
    input  logic                  reset,
    free_list_if.user             fl,
    map_update_if.user            upd,

    // dispatch, valid/ready
    input  logic                  dispatch_valid,
    input  rename_pkg::arch_idx_t dispatch_arch_dest,
    output logic                  dispatch_ready,
    output rename_pkg::rob_idx_t  dispatch_rob_idx,
    output rename_pkg::phys_idx_t dispatch_new_pr,
    output rename_pkg::phys_idx_t dispatch_old_pr,

    // completion strobe, stands in for the cdb
    input  logic                  complete_valid,
    input  rename_pkg::rob_idx_t  complete_rob_idx,

    // retirement, never stalled
    output logic                  retire_valid,
    output rename_pkg::arch_idx_t retire_arch_dest,
    output rename_pkg::phys_idx_t retire_new_pr,
    output rename_pkg::phys_idx_t retire_freed_pr
);

    typedef logic [$clog2(rename_pkg::rob_depth):0] rob_cnt_t;  // 0..depth

    ///////////////////////////////////////////////////////////////////////
    // state
    ///////////////////////////////////////////////////////////////////////

    rename_pkg::rob_entry_t entries [rename_pkg::rob_depth];

    rename_pkg::rob_idx_t head;   // oldest entry
    rename_pkg::rob_idx_t tail;   // next free slot
    rob_cnt_t             count;  // entries in flight

    logic full;    // no room for another instruction
    logic accept;  // dispatch handshake fires this edge
    logic retire;  // head leaves this edge

    ///////////////////////////////////////////////////////////////////////
    // dispatch side
    ///////////////////////////////////////////////////////////////////////

    assign full           = (count == rob_cnt_t'(rename_pkg::rob_depth));
    assign dispatch_ready = !full && !fl.empty;  // need a slot and a free reg
    assign accept         = dispatch_valid && dispatch_ready;

    // free list head becomes the new mapping in the same cycle
    assign fl.pop        = accept;
    assign upd.set_en    = accept;
    assign upd.dest_arch = dispatch_arch_dest;
    assign upd.new_pr    = fl.head_pr;

    assign dispatch_new_pr  = fl.head_pr;
    assign dispatch_old_pr  = upd.old_pr;  // mapping before this write
    assign dispatch_rob_idx = tail;

    ///////////////////////////////////////////////////////////////////////
    // retire side
    ///////////////////////////////////////////////////////////////////////

    // head done bit alone decides, count guards a stray completion on an empty buffer
    assign retire       = (count != '0) && entries[head].done;
    assign retire_valid = retire;

    assign retire_arch_dest = entries[head].arch_dest;
    assign retire_new_pr    = entries[head].new_pr;
    assign retire_freed_pr  = entries[head].old_pr;

    // old mapping is dead once its successor commits
    assign fl.push    = retire;
    assign fl.push_pr = entries[head].old_pr;

    ///////////////////////////////////////////////////////////////////////
    // pointers and count
    ///////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;  // empty
        end else begin
            if (accept) begin
                tail <= tail + 1'b1;  // wraps at 8
            end
            if (retire) begin
                head <= head + 1'b1;
            end
            case ({accept, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    ///////////////////////////////////////////////////////////////////////
    // entry storage
    ///////////////////////////////////////////////////////////////////////

    // only done bits are cleared by reset, payload is written before use
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < rename_pkg::rob_depth; i++) begin
                entries[i].done <= 1'b0;
            end
        end else begin
            if (complete_valid) begin
                entries[complete_rob_idx].done <= 1'b1;  // any order
            end
            if (retire) begin
                entries[head].done <= 1'b0;  // slot free again
            end
            if (accept) begin  // last, so a new entry always starts not done
                entries[tail].arch_dest <= dispatch_arch_dest;
                entries[tail].new_pr    <= fl.head_pr;
                entries[tail].old_pr    <= upd.old_pr;
                entries[tail].done      <= 1'b0;
            end
        end
    end

endmodule

/* source/rename_core.sv */
// rename core top; one instruction per cycle, every instruction writes a destination
module rename_core (
    input  logic                  clock,
    input  logic                  reset,

    // dispatch
    input  logic                  dispatch_valid,
    input  rename_pkg::arch_idx_t dispatch_arch_dest,
    output logic                  dispatch_ready,
    output rename_pkg::rob_idx_t  dispatch_rob_idx,
    output rename_pkg::phys_idx_t dispatch_new_pr,
    output rename_pkg::phys_idx_t dispatch_old_pr,

    // source operand lookup
    input  rename_pkg::arch_idx_t lookup_arch,
    output rename_pkg::phys_idx_t lookup_pr,

    // completion
    input  logic                  complete_valid,
    input  rename_pkg::rob_idx_t  complete_rob_idx,

    // retirement
    output logic                  retire_valid,
    output rename_pkg::arch_idx_t retire_arch_dest,
    output rename_pkg::phys_idx_t retire_new_pr,
    output rename_pkg::phys_idx_t retire_freed_pr
);

    ///////////////////////////////////////////////////////////////////////
    // peer links
    ///////////////////////////////////////////////////////////////////////

    free_list_if  fl_bus ();   // rob <-> free list
    map_update_if upd_bus ();  // rob <-> map table

    ///////////////////////////////////////////////////////////////////////
    // peers
    ///////////////////////////////////////////////////////////////////////

    map_table map_table_i (
        .clock       (clock),
        .reset       (reset),
        .upd         (upd_bus.owner),
        .lookup_arch (lookup_arch),
        .lookup_pr   (lookup_pr)
    );

    free_list free_list_i (
        .clock (clock),
        .reset (reset),
        .fl    (fl_bus.owner)
    );

    // dispatch and retirement live here
    reorder_buffer reorder_buffer_i (
        .clock              (clock),
        .reset              (reset),
        .fl                 (fl_bus.user),
        .upd                (upd_bus.user),
        .dispatch_valid     (dispatch_valid),
        .dispatch_arch_dest (dispatch_arch_dest),
        .dispatch_ready     (dispatch_ready),
        .dispatch_rob_idx   (dispatch_rob_idx),
        .dispatch_new_pr    (dispatch_new_pr),
        .dispatch_old_pr    (dispatch_old_pr),
        .complete_valid     (complete_valid),
        .complete_rob_idx   (complete_rob_idx),
        .retire_valid       (retire_valid),
        .retire_arch_dest   (retire_arch_dest),
        .retire_new_pr      (retire_new_pr),
        .retire_freed_pr    (retire_freed_pr)
    );

endmodule

/* bench/tb_clock.sv */
// free running clock, period 4 time units, starts low
module tb_clock (
    output logic clock
);

    initial begin
        clock = 1'b0;
    end

    always begin
        #2 clock = ~clock;  // half period
    end

endmodule

/* bench/rename_core_asserts.sv */
// bound into reorder_buffer; shadow state is rebuilt from the handshakes and checks idle in reset
module rename_core_asserts (
    input logic                 clock,
    input logic                 reset,
    input logic                 accept,
    input logic                 retire_valid,
    input logic                 complete_valid,
    input rename_pkg::rob_idx_t complete_rob_idx,
    input rename_pkg::rob_idx_t head,
    input rename_pkg::rob_idx_t tail,
    input logic                 pop,
    input logic                 push
);

    typedef logic [$clog2(rename_pkg::rob_depth):0]       occ_t;       // 0..depth
    typedef logic [$clog2(rename_pkg::free_list_depth):0] free_cnt_t;  // 0..depth

    occ_t                             occ;       // entries in flight, counted here
    free_cnt_t                        free_cnt;  // free registers, counted here
    logic [rename_pkg::rob_depth-1:0] seen;      // completion seen since allocation

    always_ff @(posedge clock) begin
        if (reset) begin
            occ      <= '0;
            free_cnt <= free_cnt_t'(rename_pkg::free_list_depth);
            seen     <= '0;
        end else begin
            occ      <= occ + occ_t'(accept) - occ_t'(retire_valid);
            free_cnt <= free_cnt + free_cnt_t'(push) - free_cnt_t'(pop);
            if (complete_valid) begin
                seen[complete_rob_idx] <= 1'b1;
            end
            if (accept) begin
                seen[tail] <= 1'b0;  // fresh entry starts unfinished
            end
        end
    end

    // nothing enters a full buffer
    a_no_accept_full: assert property (@(posedge clock) disable iff (reset)
        accept |-> occ < occ_t'(rename_pkg::rob_depth))
        else $error("dispatch accepted while reorder buffer full");

    a_retire_done: assert property (@(posedge clock) disable iff (reset)
        retire_valid |-> seen[head])  // head completion must have arrived
        else $error("retire_valid before the head entry completed");

    // free list underflow
    a_no_pop_empty: assert property (@(posedge clock) disable iff (reset)
        pop |-> free_cnt != '0)
        else $error("free list popped while empty");

endmodule

bind reorder_buffer rename_core_asserts asserts_i (
    .clock            (clock),
    .reset            (reset),
    .accept           (accept),
    .retire_valid     (retire_valid),
    .complete_valid   (complete_valid),
    .complete_rob_idx (complete_rob_idx),
    .head             (head),
    .tail             (tail),
    .pop              (fl.pop),
    .push             (fl.push)
);

/* bench/rename_core_tb.sv */
// self-checking bench; inputs change 1 unit after each rising edge and outputs are sampled 2 units after it
module rename_core_tb;

    localparam int k_idle = 0, k_disp = 1, k_comp = 2, k_hold = 3, k_drain = 4;
    localparam int wait_limit = 40;  // cycles per wait loop

    typedef struct {
        int kind;
        int arg;  // dispatch number for completions
    } row_t;

    typedef struct {
        rename_pkg::arch_idx_t arch_dest;
        rename_pkg::phys_idx_t new_pr;
        rename_pkg::phys_idx_t old_pr;
        rename_pkg::rob_idx_t  idx;
        bit                    done;
    } model_entry_t;

    logic clock, reset, dispatch_valid, dispatch_ready, complete_valid, retire_valid;
    rename_pkg::arch_idx_t dispatch_arch_dest, lookup_arch, retire_arch_dest;
    rename_pkg::rob_idx_t  dispatch_rob_idx, complete_rob_idx;
    rename_pkg::phys_idx_t dispatch_new_pr, dispatch_old_pr, lookup_pr;
    rename_pkg::phys_idx_t retire_new_pr, retire_freed_pr;

    // reference model
    rename_pkg::phys_idx_t model_map [rename_pkg::num_arch_regs];
    rename_pkg::phys_idx_t free_q [$];
    model_entry_t          rob_q [$];
    rename_pkg::rob_idx_t  model_tail;
    rename_pkg::rob_idx_t  disp_rob [int];  // dispatch number -> rob index
    rename_pkg::arch_idx_t last_dest;
    int                    disp_count;
    int                    errors;
    int                    timeouts;
    row_t                  table_q [$];

    tb_clock clock_i (.clock(clock));

    rename_core dut_i (.*);

    ///////////////////////////////////////////////////////////////////////
    // compare tasks
    ///////////////////////////////////////////////////////////////////////

    task automatic check_phys(rename_pkg::phys_idx_t got, rename_pkg::phys_idx_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_arch(rename_pkg::arch_idx_t got, rename_pkg::arch_idx_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_rob(rename_pkg::rob_idx_t got, rename_pkg::rob_idx_t exp, string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(logic got, logic exp, string what);
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    ///////////////////////////////////////////////////////////////////////
    // one clock: check outputs, cross the edge, advance the model
    ///////////////////////////////////////////////////////////////////////

    task automatic cycle_step(output bit taken);
        logic         exp_ready;
        logic         exp_retire;
        model_entry_t e;
        #1;  // combinational outputs settled by edge + 2
        exp_ready  = (rob_q.size() < rename_pkg::rob_depth) && (free_q.size() > 0);
        exp_retire = (rob_q.size() > 0) && rob_q[0].done;
        check_bit(dispatch_ready, exp_ready, "dispatch_ready");
        check_bit(retire_valid, exp_retire, "retire_valid");
        check_phys(lookup_pr, model_map[lookup_arch], "lookup_pr");
        if (exp_retire) begin  // oldest first, always
            check_arch(retire_arch_dest, rob_q[0].arch_dest, "retire_arch_dest");
            check_phys(retire_new_pr, rob_q[0].new_pr, "retire_new_pr");
            check_phys(retire_freed_pr, rob_q[0].old_pr, "retire_freed_pr");
        end
        taken = dispatch_valid && exp_ready;
        if (taken) begin
            check_phys(dispatch_new_pr, free_q[0], "dispatch_new_pr");  // free list order
            check_phys(dispatch_old_pr, model_map[dispatch_arch_dest], "dispatch_old_pr");
            check_rob(dispatch_rob_idx, model_tail, "dispatch_rob_idx");
        end
        @(posedge clock);
        if (exp_retire) begin
            free_q.push_back(rob_q[0].old_pr);  // freed reg rejoins at tail
            rob_q.delete(0);
        end
        if (complete_valid) begin
            foreach (rob_q[i]) begin
                if (rob_q[i].idx == complete_rob_idx) rob_q[i].done = 1'b1;
            end
        end
        if (taken) begin
            e.arch_dest = dispatch_arch_dest;
            e.new_pr    = free_q[0];
            e.old_pr    = model_map[dispatch_arch_dest];
            e.idx       = model_tail;
            e.done      = 1'b0;
            rob_q.push_back(e);
            model_map[dispatch_arch_dest] = free_q[0];
            free_q.delete(0);
            disp_rob[disp_count] = model_tail;
            disp_count++;
            model_tail++;  // wraps at 8
            last_dest = dispatch_arch_dest;
        end
        #1;  // back to the drive point at edge + 1
    endtask

    task automatic apply_row(row_t r);
        bit taken;
        int waited;
        dispatch_valid = 1'b0;
        complete_valid = 1'b0;
        lookup_arch    = last_dest;  // shows the newest mapping
        waited         = 0;
        taken          = 1'b0;
        case (r.kind)
            k_disp: begin
                dispatch_arch_dest = rename_pkg::arch_idx_t'($urandom);
                dispatch_valid     = 1'b1;
                while (!taken && waited < wait_limit) begin
                    cycle_step(taken);
                    waited++;
                end
                if (!taken) begin
                    timeouts++;
                    $display("dispatch %0d was never accepted, dispatch_ready stayed low",
                             disp_count);
                end
                dispatch_valid = 1'b0;
            end
            k_comp: begin
                complete_valid   = 1'b1;
                complete_rob_idx = disp_rob[r.arg];
                cycle_step(taken);
                complete_valid   = 1'b0;
            end
            k_hold: begin  // held against a full buffer
                dispatch_arch_dest = rename_pkg::arch_idx_t'($urandom);
                dispatch_valid     = 1'b1;
                cycle_step(taken);
                dispatch_valid     = 1'b0;
            end
            k_drain: begin  // wait on retire_valid until the model empties
                while (rob_q.size() > 0 && waited < wait_limit) begin
                    cycle_step(taken);
                    waited++;
                end
                if (rob_q.size() > 0) begin
                    timeouts++;
                    $display("reorder buffer did not drain, %0d entries never retired",
                             rob_q.size());
                end
            end
            default: cycle_step(taken);
        endcase
    endtask

    function automatic void add_row(int kind, int arg);
        row_t r;
        r.kind = kind;
        r.arg  = arg;
        table_q.push_back(r);
    endfunction

    ///////////////////////////////////////////////////////////////////////
    // main sequence
    ///////////////////////////////////////////////////////////////////////

    initial begin
        bit taken;
        void'($urandom(32'h9d2c));
        reset = 1'b1;
        dispatch_valid = 1'b0;
        dispatch_arch_dest = '0;
        lookup_arch = '0;
        complete_valid = 1'b0;
        complete_rob_idx = '0;
        errors = 0;
        timeouts = 0;
        disp_count = 0;
        model_tail = '0;
        last_dest = '0;
        for (int i = 0; i < rename_pkg::num_arch_regs; i++) begin
            model_map[i] = rename_pkg::phys_idx_t'(i);
        end
        for (int i = 0; i < rename_pkg::free_list_depth; i++) begin
            free_q.push_back(rename_pkg::phys_idx_t'(rename_pkg::num_arch_regs + i));
        end

        // four out of order completions then a full buffer with a held dispatch
        for (int i = 0; i < 4; i++) add_row(k_disp, 0);
        add_row(k_comp, 3);
        add_row(k_comp, 1);
        add_row(k_idle, 0);
        add_row(k_comp, 2);
        add_row(k_comp, 0);
        add_row(k_drain, 0);
        for (int i = 0; i < 8; i++) add_row(k_disp, 0);  // numbers 4..11
        add_row(k_hold, 0);
        add_row(k_hold, 0);
        add_row(k_comp, 4);
        add_row(k_disp, 0);  // number 12, waits for the retirement
        for (int i = 5; i <= 12; i++) add_row(k_comp, i);
        add_row(k_drain, 0);
        // enough traffic to wrap the free list onto freed regs
        for (int i = 13; i < 53; i++) begin
            add_row(k_disp, 0);
            add_row(k_comp, i);
        end
        add_row(k_drain, 0);

        repeat (2) @(posedge clock);
        #1 reset = 1'b0;
        for (int i = 0; i < 6; i++) begin  // identity mapping after reset
            lookup_arch = rename_pkg::arch_idx_t'(i * 5 + 3);
            cycle_step(taken);
        end

        foreach (table_q[i]) begin
            if (timeouts == 0) apply_row(table_q[i]);
        end

        $display("errors: %0d value mismatches, %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* project.f */
source/rename_pkg.sv
source/rename_ifs.sv
source/map_table.sv
source/free_list.sv
source/reorder_buffer.sv
source/rename_core.sv
bench/tb_clock.sv
bench/rename_core_asserts.sv
bench/rename_core_tb.sv

/* Makefile */
# Verilator build and run for the rename core testbench

VERILATOR ?= verilator
TOP       ?= rename_core_tb
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' project.f)
BIN  := $(BUILD)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): project.f $(SRCS)
	$(VERILATOR) $(VFLAGS) -f project.f --top-module $(TOP) -Mdir $(BUILD)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q '>>> FAIL' $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)
